/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_lk_flow
LOG ?= sim.log
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
lk_pkg.sv
lk_line_delay.sv
lk_gradient.sv
lk_window_sum.sv
lk_result_queue.sv
lk_flow_top.sv
tb_clock.sv
tb_lk_flow.sv

/* lk_flow_top.sv */
module lk_flow_top import lk_pkg::*;
(
	input	logic					RGB565_PCLK,
	input	logic					sys_rst_n,
	// camera side
	input	logic					frame_valid,
	input	logic					line_valid,
	input	logic					pix_valid,
	input	logic	[LUMA_W-1:0]	y_curr,
	input	logic	[LUMA_W-1:0]	y_prev,
	// sink side
	input	logic					credit_return,
	output	result_t				out_sums,
	output	logic					out_valid,
	output	logic					overflow
);
	grad_t		grad;
	logic		grad_valid;
	logic		grad_line_valid;
	result_t	sums;
	logic		sum_valid;	// cycle 5 after pix_valid, queue write

	////////////////////
	// stage 1
	lk_gradient u_gradient (
		.RGB565_PCLK		(RGB565_PCLK),
		.sys_rst_n			(sys_rst_n),
		.frame_valid		(frame_valid),
		.line_valid			(line_valid),
		.pix_valid			(pix_valid),
		.y_curr				(y_curr),
		.y_prev				(y_prev),
		.grad				(grad),
		.grad_valid			(grad_valid),
		.grad_line_valid	(grad_line_valid)
	);

	////////////////////
	// stages 2 to 5
	lk_window_sum u_window_sum (
		.RGB565_PCLK		(RGB565_PCLK),
		.sys_rst_n			(sys_rst_n),
		.frame_valid		(frame_valid),
		.grad				(grad),
		.grad_valid			(grad_valid),
		.grad_line_valid	(grad_line_valid),
		.sums				(sums),
		.sum_valid			(sum_valid)
	);

	////////////////////
	// output queue, credit paced
	lk_result_queue u_result_queue (
		.RGB565_PCLK		(RGB565_PCLK),
		.sys_rst_n			(sys_rst_n),
		.wr_data			(sums),
		.wr_en				(sum_valid),
		.credit_return		(credit_return),
		.out_sums			(out_sums),
		.out_valid			(out_valid),
		.overflow			(overflow)
	);

endmodule

/* lk_gradient.sv */
module lk_gradient import lk_pkg::*;
(
	input	logic					RGB565_PCLK,
	input	logic					sys_rst_n,
	input	logic					frame_valid,
	input	logic					line_valid,
	input	logic					pix_valid,
	input	logic	[LUMA_W-1:0]	y_curr,
	input	logic	[LUMA_W-1:0]	y_prev,
	output	grad_t					grad,
	output	logic					grad_valid,
	output	logic					grad_line_valid
);
	logic	[LUMA_W-1:0]	y_left;		// left neighbour in the same line
	logic	[LUMA_W-1:0]	y_above;	// same column, one line up

	// unsigned luma to signed difference
	function automatic logic signed [GRAD_W-1:0] diff(
		input logic [LUMA_W-1:0] a,
		input logic [LUMA_W-1:0] b
	);
		return $signed(GRAD_W'(a)) - $signed(GRAD_W'(b));
	endfunction

	lk_line_delay #(
		.payload_t	(logic [LUMA_W-1:0]),
		.DEPTH		(H_PIXELS)
	) u_luma_line (
		.RGB565_PCLK	(RGB565_PCLK),
		.sys_rst_n		(sys_rst_n),
		.clear			(!frame_valid),	// row above the first line reads 0
		.shift_en		(pix_valid),
		.din			(y_curr),
		.dout			(y_above)
	);

	// zero between lines so the first pixel sees 0 on its left
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n || !line_valid)
			y_left <= '0;
		else if (pix_valid)
			y_left <= y_curr;
	end

	////////////////////
	// stage 1
	always_ff @(posedge RGB565_PCLK)
	begin
		if (pix_valid)
		begin
			grad.ix <= diff(y_curr, y_left);
			grad.iy <= diff(y_curr, y_above);
			grad.it <= diff(y_curr, y_prev);	// temporal
		end
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			grad_valid <= 1'b0;
			grad_line_valid <= 1'b0;
		end
		else
		begin
			grad_valid <= pix_valid;
			grad_line_valid <= line_valid;
		end
	end

endmodule

/* lk_line_delay.sv */
module lk_line_delay import lk_pkg::*;
#(
	parameter type	payload_t	= logic [LUMA_W-1:0],
	parameter int	DEPTH		= H_PIXELS
)
(
	input	logic		RGB565_PCLK,
	input	logic		sys_rst_n,
	input	logic		clear,
	input	logic		shift_en,
	input	payload_t	din,
	output	payload_t	dout
);
	// taps[0] newest, taps[DEPTH-1] written one line ago
	payload_t	taps [DEPTH];

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n || clear)
		begin
			for (int i = 0; i < DEPTH; i++)
				taps[i] <= '0;
		end
		else if (shift_en)	// only valid pixels advance the line
		begin
			taps[0] <= din;
			for (int i = 1; i < DEPTH; i++)
				taps[i] <= taps[i-1];
		end
	end

	// read straight from storage, no output register
	assign dout = taps[DEPTH-1];

endmodule

/* lk_pkg.sv */
package lk_pkg;

	////////////////////
	// frame geometry
	localparam int H_PIXELS = 16;	// active pixels per line
	localparam int WIN = 5;			// window is WIN x WIN

	////////////////////
	// datapath widths
	localparam int LUMA_W = 8;
	localparam int GRAD_W = 9;		// signed difference of two luma values
	localparam int PROD_W = 18;		// gradient times gradient
	localparam int SUM_W = 22;		// holds 25 full scale products

	////////////////////
	// result queue and credits
	localparam int QUEUE_DEPTH = 128;
	localparam int QUEUE_AW = $clog2(QUEUE_DEPTH);
	localparam int CREDITS_MAX = 8;	// sender starts with this many
	localparam int CREDIT_W = $clog2(CREDITS_MAX + 1);

	// one pixel worth of gradients
	typedef struct packed
	{
		logic signed	[GRAD_W-1:0]	ix;
		logic signed	[GRAD_W-1:0]	iy;
		logic signed	[GRAD_W-1:0]	it;
	} grad_t;

	// structure tensor sums over the window
	typedef struct packed
	{
		logic signed	[SUM_W-1:0]		ixix;
		logic signed	[SUM_W-1:0]		ixiy;
		logic signed	[SUM_W-1:0]		iyiy;
		logic signed	[SUM_W-1:0]		ixit;
		logic signed	[SUM_W-1:0]		iyit;
	} result_t;

endpackage

/* lk_result_queue.sv */
module lk_result_queue import lk_pkg::*;
(
	input	logic		RGB565_PCLK,
	input	logic		sys_rst_n,
	input	result_t	wr_data,
	input	logic		wr_en,
	input	logic		credit_return,
	output	result_t	out_sums,
	output	logic		out_valid,
	output	logic		overflow
);
	result_t				mem [QUEUE_DEPTH];
	logic	[QUEUE_AW:0]	wr_ptr;		// extra bit tells full from empty
	logic	[QUEUE_AW:0]	rd_ptr;
	logic	[CREDIT_W-1:0]	credits;	// results the sink can still take
	logic					empty;
	logic					full;
	logic					send;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[QUEUE_AW] != rd_ptr[QUEUE_AW]) &&
		(wr_ptr[QUEUE_AW-1:0] == rd_ptr[QUEUE_AW-1:0]);
	assign send = !empty && (credits != '0);

	////////////////////
	// write side
	always_ff @(posedge RGB565_PCLK)
	begin
		if (wr_en && !full)
			mem[wr_ptr[QUEUE_AW-1:0]] <= wr_data;
	end

	// camera cannot stall, so a full queue drops the result
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			wr_ptr <= '0;
			overflow <= 1'b0;
		end
		else if (wr_en)
		begin
			if (full)
				overflow <= 1'b1;	// sticky
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	////////////////////
	// read side
	always_ff @(posedge RGB565_PCLK)
	begin
		if (send)
			out_sums <= mem[rd_ptr[QUEUE_AW-1:0]];
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			rd_ptr <= '0;
			out_valid <= 1'b0;
			credits <= CREDIT_W'(CREDITS_MAX);
		end
		else
		begin
			out_valid <= send;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			// spend and return in one cycle cancel out
			case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

/* lk_window_sum.sv */
module lk_window_sum import lk_pkg::*;
(
	input	logic		RGB565_PCLK,
	input	logic		sys_rst_n,
	input	logic		frame_valid,
	input	grad_t		grad,
	input	logic		grad_valid,
	input	logic		grad_line_valid,
	output	result_t	sums,
	output	logic		sum_valid
);
	// the five products of one triple
	typedef struct packed
	{
		logic signed	[PROD_W-1:0]	ixix;
		logic signed	[PROD_W-1:0]	ixiy;
		logic signed	[PROD_W-1:0]	iyiy;
		logic signed	[PROD_W-1:0]	ixit;
		logic signed	[PROD_W-1:0]	iyit;
	} prod_t;

	grad_t		rows [WIN];			// rows[k] is k lines above
	grad_t		win [WIN][WIN];		// [row][col], col 0 newest
	grad_t		leave [WIN];		// column pushed out by the last shift
	prod_t		prod_in [WIN];
	prod_t		prod_out [WIN];
	result_t	col_in_d;
	result_t	col_out_d;
	result_t	col_in;
	result_t	col_out;
	logic		v2, v3, v4;			// pixel valid per stage
	logic		lv2, lv3, lv4;		// line valid per stage

	function automatic prod_t products(grad_t g);
		prod_t p;
		p.ixix = g.ix * g.ix;
		p.ixiy = g.ix * g.iy;
		p.iyiy = g.iy * g.iy;
		p.ixit = g.ix * g.it;
		p.iyit = g.iy * g.it;
		return p;
	endfunction

	function automatic result_t accumulate(result_t acc, prod_t p);
		result_t r;
		r.ixix = acc.ixix + p.ixix;
		r.ixiy = acc.ixiy + p.ixiy;
		r.iyiy = acc.iyiy + p.iyiy;
		r.ixit = acc.ixit + p.ixit;
		r.iyit = acc.iyit + p.iyit;
		return r;
	endfunction

	assign rows[0] = grad;

	// four line delays in a chain give rows y-1 .. y-4
	generate
		for (genvar k = 0; k < WIN-1; k++)
		begin : g_rows
			lk_line_delay #(
				.payload_t	(grad_t)
			) u_row (
				.RGB565_PCLK	(RGB565_PCLK),
				.sys_rst_n		(sys_rst_n),
				.clear			(!frame_valid),
				.shift_en		(grad_valid),
				.din			(rows[k]),
				.dout			(rows[k+1])
			);
		end
	endgenerate

	////////////////////
	// stage 2, window shift
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n || !grad_line_valid)	// left border reads as zero
		begin
			for (int r = 0; r < WIN; r++)
			begin
				for (int c = 0; c < WIN; c++)
					win[r][c] <= '0;
				leave[r] <= '0;
			end
		end
		else if (grad_valid)
		begin
			for (int r = 0; r < WIN; r++)
			begin
				win[r][0] <= rows[r];
				for (int c = 1; c < WIN; c++)
					win[r][c] <= win[r][c-1];
				leave[r] <= win[r][WIN-1];
			end
		end
	end

	////////////////////
	// stage 3, products of entering and leaving columns
	always_ff @(posedge RGB565_PCLK)
	begin
		for (int r = 0; r < WIN; r++)
		begin
			prod_in[r] <= products(win[r][0]);
			prod_out[r] <= products(leave[r]);
		end
	end

	////////////////////
	// stage 4, column sums
	always_comb
	begin
		col_in_d = '0;
		col_out_d = '0;
		for (int r = 0; r < WIN; r++)
		begin
			col_in_d = accumulate(col_in_d, prod_in[r]);
			col_out_d = accumulate(col_out_d, prod_out[r]);
		end
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		col_in <= col_in_d;
		col_out <= col_out_d;
	end

	////////////////////
	// stage 5, running window sums
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n || !lv4)
			sums <= '0;
		else if (v4)
		begin
			sums.ixix <= sums.ixix + col_in.ixix - col_out.ixix;
			sums.ixiy <= sums.ixiy + col_in.ixiy - col_out.ixiy;
			sums.iyiy <= sums.iyiy + col_in.iyiy - col_out.iyiy;
			sums.ixit <= sums.ixit + col_in.ixit - col_out.ixit;
			sums.iyit <= sums.iyit + col_in.iyit - col_out.iyit;
		end
	end

	// flags follow the data through the stages
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			{v2, v3, v4, sum_valid} <= '0;
			{lv2, lv3, lv4} <= '0;
		end
		else
		begin
			v2 <= grad_valid;
			v3 <= v2;
			v4 <= v3;
			sum_valid <= v4;
			lv2 <= grad_line_valid;
			lv3 <= lv2;
			lv4 <= lv3;
		end
	end

endmodule

/* tb_clock.sv */
module tb_clock
#(
	parameter int	HALF_PERIOD		= 2,	// 4 ns period
	parameter int	RESET_CYCLES	= 8
)
(
	output	logic	RGB565_PCLK,
	output	logic	sys_rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		RGB565_PCLK = 1'b0;
		forever
			#(HALF_PERIOD) RGB565_PCLK = ~RGB565_PCLK;
	end

	// reset released on a rising edge
	initial
	begin
		sys_rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge RGB565_PCLK);
		sys_rst_n <= 1'b1;
	end

endmodule

/* tb_lk_flow.sv */
module tb_lk_flow import lk_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINES = 6;
	localparam int FRAME_PIX = LINES * H_PIXELS;
	localparam int WAIT_LIMIT = 4000;	// cycles per wait loop

	logic					RGB565_PCLK;
	logic					sys_rst_n;
	logic					frame_valid;
	logic					line_valid;
	logic					pix_valid;
	logic	[LUMA_W-1:0]	y_curr;
	logic	[LUMA_W-1:0]	y_prev;
	logic					credit_return = 1'b0;
	result_t				out_sums;
	logic					out_valid;
	logic					overflow;

	int			cur_y [LINES][H_PIXELS];
	int			prev_y [LINES][H_PIXELS];
	result_t	exp_q [$];				// model results in pixel order
	int			seed = 32'h5771468b;
	int			received = 0;
	int			outstanding = 0;		// results not yet credited back
	int			credit_period = 0;		// 0 holds every credit
	int			tick = 0;
	bit			no_temporal = 1'b0;		// static scene where IxIt and IyIt are 0
	int			value_errors = 0;
	int			protocol_errors = 0;
	int			timeout_errors = 0;

	tb_clock #(.HALF_PERIOD(2), .RESET_CYCLES(8)) u_clock (
		.RGB565_PCLK	(RGB565_PCLK),
		.sys_rst_n		(sys_rst_n)
	);

	lk_flow_top dut0 (
		.RGB565_PCLK	(RGB565_PCLK),
		.sys_rst_n		(sys_rst_n),
		.frame_valid	(frame_valid),
		.line_valid		(line_valid),
		.pix_valid		(pix_valid),
		.y_curr			(y_curr),
		.y_prev			(y_prev),
		.credit_return	(credit_return),
		.out_sums		(out_sums),
		.out_valid		(out_valid),
		.overflow		(overflow)
	);

	////////////////////
	// sink compares in order and returns credits
	always @(posedge RGB565_PCLK)
	begin
		result_t	want;
		bit			give;
		give = 1'b0;
		if (sys_rst_n && out_valid)
		begin
			received++;
			outstanding++;
			if (exp_q.size() == 0)
			begin
				$display("result arrived with nothing left in the model queue");
				protocol_errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				assert (out_sums == want)
				else
				begin
					$display("CHECK FAILED out_sums got %h expected %h", out_sums, want);
					value_errors++;
				end
				assert (!no_temporal || (out_sums.ixit == '0 && out_sums.iyit == '0))
				else
				begin
					$display("CHECK FAILED out_sums.ixit/iyit got %h %h expected 0",
						out_sums.ixit, out_sums.iyit);
					value_errors++;
				end
			end
		end
		assert (outstanding <= CREDITS_MAX)
		else
		begin
			$display("CHECK FAILED outstanding got %h limit %h", outstanding, CREDITS_MAX);
			value_errors++;
		end
		tick++;
		if (sys_rst_n && credit_period != 0 && outstanding > 0 && tick % credit_period == 0)
			give = 1'b1;
		if (give)
			outstanding--;
		credit_return <= give;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got == want)
		else
		begin
			$display("CHECK FAILED %0s got %h expected %h", name, got, want);
			value_errors++;
		end
	endtask

	task automatic set_mode(input int period, input bit static_scene);
		@(negedge RGB565_PCLK);	// away from the sink's edge
		credit_period = period;
		no_temporal = static_scene;
	endtask

	task automatic fill_frame(input bit random_luma);
		for (int y = 0; y < LINES; y++)
			for (int x = 0; x < H_PIXELS; x++)
			begin
				if (random_luma)
				begin
					cur_y[y][x] = $random(seed) & 255;
					prev_y[y][x] = $random(seed) & 255;
				end
				else
				begin
					cur_y[y][x] = x * 9 + y * 13;	// ramp
					prev_y[y][x] = cur_y[y][x];
				end
			end
	endtask

	////////////////////
	// reference model
	task automatic model_frame();
		int			gx [LINES][H_PIXELS];
		int			gy [LINES][H_PIXELS];
		int			gt [LINES][H_PIXELS];
		int			s [5];
		result_t	r;
		for (int y = 0; y < LINES; y++)
			for (int x = 0; x < H_PIXELS; x++)
			begin
				gx[y][x] = cur_y[y][x] - ((x > 0) ? cur_y[y][x-1] : 0);
				gy[y][x] = cur_y[y][x] - ((y > 0) ? cur_y[y-1][x] : 0);
				gt[y][x] = cur_y[y][x] - prev_y[y][x];
			end
		for (int y = 0; y < LINES; y++)
			for (int x = 0; x < H_PIXELS; x++)
			begin
				s = '{default: 0};
				for (int wy = y - WIN + 1; wy <= y; wy++)
					for (int wx = x - WIN + 1; wx <= x; wx++)
						if (wy >= 0 && wx >= 0)	// outside the frame counts as 0
						begin
							s[0] += gx[wy][wx] * gx[wy][wx];
							s[1] += gx[wy][wx] * gy[wy][wx];
							s[2] += gy[wy][wx] * gy[wy][wx];
							s[3] += gx[wy][wx] * gt[wy][wx];
							s[4] += gy[wy][wx] * gt[wy][wx];
						end
				r.ixix = SUM_W'(s[0]);
				r.ixiy = SUM_W'(s[1]);
				r.iyiy = SUM_W'(s[2]);
				r.ixit = SUM_W'(s[3]);
				r.iyit = SUM_W'(s[4]);
				exp_q.push_back(r);
			end
	endtask

	task automatic send_frame();
		@(negedge RGB565_PCLK);
		model_frame();
		@(posedge RGB565_PCLK);
		frame_valid <= 1'b1;
		repeat (3) @(posedge RGB565_PCLK);
		for (int y = 0; y < LINES; y++)
		begin
			for (int x = 0; x < H_PIXELS; x++)
			begin
				line_valid <= 1'b1;
				pix_valid <= 1'b1;
				y_curr <= LUMA_W'(cur_y[y][x]);
				y_prev <= LUMA_W'(prev_y[y][x]);
				@(posedge RGB565_PCLK);
			end
			line_valid <= 1'b0;
			pix_valid <= 1'b0;
			repeat (4) @(posedge RGB565_PCLK);	// line blanking
		end
		repeat (3) @(posedge RGB565_PCLK);
		frame_valid <= 1'b0;
		repeat (3) @(posedge RGB565_PCLK);
	endtask

	////////////////////
	// bounded waits
	task automatic wait_reset();
		int n;
		n = 0;
		while (sys_rst_n !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge RGB565_PCLK);
			n++;
		end
		if (sys_rst_n !== 1'b1)
		begin
			$display("reset was never released");
			timeout_errors++;
		end
	endtask

	task automatic wait_results(input int target);
		int n;
		n = 0;
		while (received < target && n < WAIT_LIMIT)
		begin
			@(negedge RGB565_PCLK);
			n++;
		end
		if (received < target)
		begin
			$display("timed out with %0d of %0d results received", received, target);
			timeout_errors++;
		end
	endtask

	task automatic wait_settled();
		int n;
		n = 0;
		while ((outstanding != 0 || exp_q.size() != 0) && n < WAIT_LIMIT)
		begin
			@(negedge RGB565_PCLK);
			n++;
		end
		if (outstanding != 0 || exp_q.size() != 0)
		begin
			$display("timed out with %0d credits held and %0d results missing",
				outstanding, exp_q.size());
			timeout_errors++;
		end
	endtask

	task automatic wait_overflow();
		int n;
		n = 0;
		while (overflow !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge RGB565_PCLK);
			n++;
		end
		if (overflow !== 1'b1)
		begin
			$display("overflow flag never went high");
			timeout_errors++;
		end
	endtask

	////////////////////
	// tests
	task automatic test_reset();
		@(negedge RGB565_PCLK);
		check_value("out_valid", 32'(out_valid), 0);
		check_value("overflow", 32'(overflow), 0);
		repeat (40) @(negedge RGB565_PCLK);	// nothing may come out with idle inputs
		check_value("received", received, 0);
	endtask

	task automatic run_frame(input int period, input bit static_scene);
		int start;
		set_mode(period, static_scene);
		start = received;
		fill_frame(!static_scene);
		send_frame();
		wait_results(start + FRAME_PIX);
		wait_settled();
		check_value("received", received - start, FRAME_PIX);
		check_value("overflow", 32'(overflow), 0);	// one frame never fills the queue
	endtask

	task automatic test_overflow();
		int start;
		set_mode(0, 1'b0);
		start = received;
		fill_frame(1'b1);
		send_frame();
		fill_frame(1'b1);
		send_frame();
		wait_overflow();
		check_value("received", received - start, CREDITS_MAX);
		set_mode(1, 1'b0);
		wait_results(start + CREDITS_MAX + QUEUE_DEPTH);
		repeat (40) @(negedge RGB565_PCLK);	// queue must stay quiet now
		check_value("received", received - start - CREDITS_MAX, QUEUE_DEPTH);
		check_value("dropped", exp_q.size(), 2 * FRAME_PIX - QUEUE_DEPTH - CREDITS_MAX);
		exp_q.delete();
		wait_settled();
	endtask

	initial
	begin
		frame_valid = 1'b0;
		line_valid = 1'b0;
		pix_valid = 1'b0;
		y_curr = '0;
		y_prev = '0;
		wait_reset();
		test_reset();
		run_frame(1, 1'b1);		// static ramp
		run_frame(1, 1'b0);		// random luma
		run_frame(6, 1'b0);		// slow credits
		test_overflow();
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
